// File: dircc_consts.svh
`ifndef DIRCC_CONSTS_SVH
`define DIRCC_CONSTS_SVH

// stream beat geometry
`define DIRCC_BEAT_WIDTH 32
`define DIRCC_EMPTY_WIDTH 2
`define DIRCC_BEATS_PER_PACKET 8

// node address fields carried in the second address beat
`define DIRCC_SW_ADDR_WIDTH 16
`define DIRCC_PORT_WIDTH 7

// five header beats, the rest are payload
`define DIRCC_DATA_WIDTH ((`DIRCC_BEATS_PER_PACKET - 5) * `DIRCC_BEAT_WIDTH)

`define DIRCC_IN_FIFO_DEPTH 8
`define DIRCC_OUT_FIFO_DEPTH 4

`define DIRCC_BROADCAST_HW_ADDR 32'hffff_ffff

// register port and counters
`define DIRCC_REG_WIDTH 32
`define DIRCC_COUNT_WIDTH 16

`endif

// File: dircc_types_pkg.sv
`include "dircc_consts.svh"

package dircc_types_pkg;

  typedef struct packed {
    logic [`DIRCC_BEAT_WIDTH-1:0]    hw_addr;
    logic [`DIRCC_SW_ADDR_WIDTH-1:0] sw_addr;
    logic [`DIRCC_PORT_WIDTH-1:0]    port;
    logic                            flag;
  } address_t; // 56 bits

  typedef struct packed {
    address_t                        dest_addr;
    address_t                        src_addr;
    logic [`DIRCC_BEAT_WIDTH-1:0]    lamport;
    logic [`DIRCC_DATA_WIDTH-1:0]    data;
  } packet_t; // 240 bits

endpackage : dircc_types_pkg

// File: dircc_stream_pkg.sv
`include "dircc_consts.svh"

package dircc_stream_pkg;

  typedef struct packed {
    logic [`DIRCC_BEAT_WIDTH-1:0]  data;
    logic [`DIRCC_EMPTY_WIDTH-1:0] empty;
    logic                          sop;
    logic                          eop;
  } beat_t;

  typedef enum logic [1:0] {
    REG_OWN_ADDR  = 2'd0, // rw
    REG_CONTROL   = 2'd1, // bit 0 enable, bit 1 accept broadcast
    REG_DELIVERED = 2'd2, // ro
    REG_ERRORS    = 2'd3  // framing hi, dropped lo, write clears
  } reg_addr_t;

endpackage : dircc_stream_pkg

// File: dircc_rx_status_if.sv
`timescale 1ns/1ns
`include "dircc_consts.svh"

interface dircc_rx_status_if;

  logic [`DIRCC_BEAT_WIDTH-1:0] own_hw_addr;
  logic                         enable;
  logic                         accept_bcast;

  logic                         packet_done;   // record assembled
  logic                         framing_error; // bad sop/eop seen
  logic                         delivered;     // pushed to output fifo
  logic                         dropped;       // filtered or no room

  modport regs (
    output own_hw_addr,
    output enable,
    output accept_bcast,
    input  packet_done,
    input  framing_error,
    input  delivered,
    input  dropped
  );

  modport datapath (
    input  own_hw_addr,
    input  enable,
    input  accept_bcast,
    output packet_done,
    output framing_error,
    output delivered,
    output dropped
  );

endinterface : dircc_rx_status_if

// File: dircc_sync_fifo.sv
`timescale 1ns/1ns

module dircc_sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     reset_n,
  input  payload_t in_payload,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_payload,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  payload_t               mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic [COUNT_WIDTH-1:0] count_next;
  logic                   push;
  logic                   pop;

  assign push        = in_valid && in_ready;
  assign pop         = out_valid && out_ready;
  assign out_valid   = (count != '0);
  assign out_payload = mem[rd_ptr]; // show-ahead read

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_payload;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0; // held low through reset
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count_next;
      in_ready <= (count_next != COUNT_WIDTH'(DEPTH));
    end
  end

endmodule : dircc_sync_fifo

// File: dircc_packet_receiver.sv
`timescale 1ns/1ns
`include "dircc_consts.svh"

module dircc_packet_receiver (
  input  logic                     clk,
  input  logic                     reset_n,
  input  dircc_stream_pkg::beat_t  beat,
  input  logic                     beat_valid,
  output logic                     beat_ready,
  output dircc_types_pkg::packet_t pkt,
  output logic                     pkt_valid,
  dircc_rx_status_if.datapath      status
);

  localparam int W = `DIRCC_BEAT_WIDTH;

  typedef enum logic [3:0] {
    DEST_ADDR0,
    DEST_ADDR1,
    SRC_ADDR0,
    SRC_ADDR1,
    LAMPORT,
    DATA0,
    DATA1,
    DATA2,
    DISCARD
  } state_t;

  state_t                   state;
  dircc_types_pkg::packet_t temp_pkt;
  logic                     accept;

  assign beat_ready         = !pkt_valid; // one idle cycle per packet
  assign accept             = beat_valid && beat_ready;
  assign status.packet_done = pkt_valid;

  // field capture
  always_ff @(posedge clk) begin
    if (accept) begin
      case (state)
        DEST_ADDR0: temp_pkt.dest_addr.hw_addr <= beat.data;
        DEST_ADDR1: begin
          {temp_pkt.dest_addr.sw_addr, temp_pkt.dest_addr.port,
           temp_pkt.dest_addr.flag} <= beat.data[W-1:8];
        end
        SRC_ADDR0:  temp_pkt.src_addr.hw_addr <= beat.data;
        SRC_ADDR1: begin
          {temp_pkt.src_addr.sw_addr, temp_pkt.src_addr.port,
           temp_pkt.src_addr.flag} <= beat.data[W-1:8];
        end
        LAMPORT:    temp_pkt.lamport <= beat.data;
        DATA0:      temp_pkt.data[0 +: W] <= beat.data;
        DATA1:      temp_pkt.data[W +: W] <= beat.data;
        DATA2: begin
          pkt                <= temp_pkt;
          pkt.data[2*W +: W] <= beat.data; // last beat straight into output
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state                <= DEST_ADDR0;
      pkt_valid            <= 1'b0;
      status.framing_error <= 1'b0;
    end else begin
      pkt_valid            <= 1'b0;
      status.framing_error <= 1'b0;
      if (accept) begin
        case (state)
          DEST_ADDR0: begin
            if (!beat.sop || beat.eop) begin
              status.framing_error <= 1'b1;
              state <= beat.eop ? DEST_ADDR0 : DISCARD; // eop already ends it
            end else begin
              state <= DEST_ADDR1;
            end
          end
          DATA2: begin
            if (beat.eop) begin
              pkt_valid <= 1'b1;
              state     <= DEST_ADDR0;
            end else begin
              status.framing_error <= 1'b1; // missing eop
              state <= DISCARD;
            end
          end
          DISCARD: begin
            if (beat.eop) begin
              state <= DEST_ADDR0;
            end
          end
          default: begin
            if (beat.eop) begin
              status.framing_error <= 1'b1; // early eop
              state <= DEST_ADDR0;
            end else begin
              state <= state_t'(state + 1'b1);
            end
          end
        endcase
      end
    end
  end

endmodule : dircc_packet_receiver

// File: dircc_address_filter.sv
`timescale 1ns/1ns
`include "dircc_consts.svh"

module dircc_address_filter (
  input  logic                     clk,
  input  logic                     reset_n,
  input  dircc_types_pkg::packet_t pkt,
  input  logic                     pkt_valid,
  output dircc_types_pkg::packet_t push_packet,
  output logic                     push_valid,
  input  logic                     push_ready,
  dircc_rx_status_if.datapath      status
);

  logic own_match;
  logic bcast_match;
  logic keep;

  assign own_match   = (pkt.dest_addr.hw_addr == status.own_hw_addr);
  assign bcast_match = status.accept_bcast &&
                       (pkt.dest_addr.hw_addr == `DIRCC_BROADCAST_HW_ADDR);

  // no room means drop, the receiver is never stalled
  assign keep = status.enable && (own_match || bcast_match) && push_ready;

  assign status.delivered = push_valid;

  always_ff @(posedge clk) begin
    if (pkt_valid) begin
      push_packet <= pkt;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      push_valid     <= 1'b0;
      status.dropped <= 1'b0;
    end else begin
      push_valid     <= pkt_valid && keep;
      status.dropped <= pkt_valid && !keep;
    end
  end

endmodule : dircc_address_filter

// File: dircc_receive_regs.sv
`timescale 1ns/1ns
`include "dircc_consts.svh"

module dircc_receive_regs (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        cfg_req,
  input  logic                        cfg_write,
  input  dircc_stream_pkg::reg_addr_t cfg_addr,
  input  logic [`DIRCC_REG_WIDTH-1:0] cfg_wdata,
  output logic [`DIRCC_REG_WIDTH-1:0] cfg_rdata,
  output logic                        cfg_ack,
  dircc_rx_status_if.regs             status
);

  localparam int CW = `DIRCC_COUNT_WIDTH;

  logic [`DIRCC_BEAT_WIDTH-1:0] own_hw_addr;
  logic                         enable;
  logic                         accept_bcast;
  logic [`DIRCC_REG_WIDTH-1:0]  delivered_count;
  logic [CW-1:0]                framing_count;
  logic [CW-1:0]                dropped_count;
  logic                         pending;
  logic                         counter_access;
  logic                         access;
  logic                         clear_errors;

  assign status.own_hw_addr  = own_hw_addr;
  assign status.enable       = enable;
  assign status.accept_bcast = accept_bcast;

  // a counter access waits while a packet outcome is still on its way
  assign counter_access = (cfg_addr == dircc_stream_pkg::REG_DELIVERED) ||
                          (cfg_addr == dircc_stream_pkg::REG_ERRORS);
  assign access = cfg_req && !cfg_ack &&
                  !(counter_access && (pending || status.packet_done));
  assign clear_errors = access && cfg_write && (cfg_addr == dircc_stream_pkg::REG_ERRORS);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cfg_ack      <= 1'b0;
      cfg_rdata    <= '0;
      own_hw_addr  <= '0;
      enable       <= 1'b0;
      accept_bcast <= 1'b0;
      pending      <= 1'b0;
    end else begin
      if (status.packet_done) begin
        pending <= 1'b1;
      end else if (status.delivered || status.dropped) begin
        pending <= 1'b0;
      end
      if (!cfg_req) begin
        cfg_ack <= 1'b0; // four-phase return to idle
      end else if (access) begin
        cfg_ack <= 1'b1;
        if (cfg_write) begin
          case (cfg_addr)
            dircc_stream_pkg::REG_OWN_ADDR: own_hw_addr <= cfg_wdata;
            dircc_stream_pkg::REG_CONTROL:  {accept_bcast, enable} <= cfg_wdata[1:0];
            default: ;
          endcase
        end
        case (cfg_addr)
          dircc_stream_pkg::REG_OWN_ADDR:  cfg_rdata <= own_hw_addr;
          dircc_stream_pkg::REG_CONTROL:   cfg_rdata <= {30'd0, accept_bcast, enable};
          dircc_stream_pkg::REG_DELIVERED: cfg_rdata <= delivered_count;
          default:                         cfg_rdata <= {framing_count, dropped_count};
        endcase
      end
    end
  end

  // saturating event counters
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      delivered_count <= '0;
      framing_count   <= '0;
      dropped_count   <= '0;
    end else begin
      if (status.delivered && (delivered_count != '1)) begin
        delivered_count <= delivered_count + 1'b1;
      end
      if (clear_errors) begin
        framing_count <= '0;
        dropped_count <= '0;
      end else begin
        if (status.framing_error && (framing_count != '1)) begin
          framing_count <= framing_count + 1'b1;
        end
        if (status.dropped && (dropped_count != '1)) begin
          dropped_count <= dropped_count + 1'b1;
        end
      end
    end
  end

endmodule : dircc_receive_regs

// File: dircc_receive_top.sv
`timescale 1ns/1ns
`include "dircc_consts.svh"

module dircc_receive_top (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic [`DIRCC_BEAT_WIDTH-1:0]  in_data,
  input  logic [`DIRCC_EMPTY_WIDTH-1:0] in_empty,
  input  logic                          in_sop,
  input  logic                          in_eop,
  input  logic                          in_valid,
  output logic                          in_ready,
  output dircc_types_pkg::packet_t      out_packet,
  output logic                          out_valid,
  input  logic                          out_ready,
  input  logic                          cfg_req,
  input  logic                          cfg_write,
  input  dircc_stream_pkg::reg_addr_t   cfg_addr,
  input  logic [`DIRCC_REG_WIDTH-1:0]   cfg_wdata,
  output logic [`DIRCC_REG_WIDTH-1:0]   cfg_rdata,
  output logic                          cfg_ack
);

  dircc_stream_pkg::beat_t  in_beat;
  dircc_stream_pkg::beat_t  rx_beat;
  logic                     rx_beat_valid;
  logic                     rx_beat_ready;
  dircc_types_pkg::packet_t rx_pkt;
  logic                     rx_pkt_valid;
  dircc_types_pkg::packet_t push_packet;
  logic                     push_valid;
  logic                     push_ready;

  dircc_rx_status_if status_if ();

  assign in_beat = '{data: in_data, empty: in_empty, sop: in_sop, eop: in_eop};

  dircc_sync_fifo #(
    .payload_t (dircc_stream_pkg::beat_t),
    .DEPTH     (`DIRCC_IN_FIFO_DEPTH)
  ) i_in_fifo (
    .clk         (clk),
    .reset_n     (reset_n),
    .in_payload  (in_beat),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .out_payload (rx_beat),
    .out_valid   (rx_beat_valid),
    .out_ready   (rx_beat_ready)
  );

  dircc_packet_receiver i_receiver (
    .clk        (clk),
    .reset_n    (reset_n),
    .beat       (rx_beat),
    .beat_valid (rx_beat_valid),
    .beat_ready (rx_beat_ready),
    .pkt        (rx_pkt),
    .pkt_valid  (rx_pkt_valid),
    .status     (status_if)
  );

  dircc_address_filter i_filter (
    .clk         (clk),
    .reset_n     (reset_n),
    .pkt         (rx_pkt),
    .pkt_valid   (rx_pkt_valid),
    .push_packet (push_packet),
    .push_valid  (push_valid),
    .push_ready  (push_ready),
    .status      (status_if)
  );

  dircc_sync_fifo #(
    .payload_t (dircc_types_pkg::packet_t),
    .DEPTH     (`DIRCC_OUT_FIFO_DEPTH)
  ) i_out_fifo (
    .clk         (clk),
    .reset_n     (reset_n),
    .in_payload  (push_packet),
    .in_valid    (push_valid),
    .in_ready    (push_ready),
    .out_payload (out_packet),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

  dircc_receive_regs i_regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .cfg_req   (cfg_req),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .cfg_ack   (cfg_ack),
    .status    (status_if)
  );

endmodule : dircc_receive_top

// File: dircc_receive_properties.sv
`timescale 1ns/1ns
`include "dircc_consts.svh"

module dircc_receive_properties (
  input logic                     clk,
  input logic                     reset_n,
  input logic                     in_valid,
  input logic                     in_ready,
  input logic                     beat_valid,
  input logic                     beat_ready,
  input dircc_types_pkg::packet_t out_packet,
  input logic                     out_valid,
  input logic                     out_ready,
  input logic                     cfg_req,
  input logic                     cfg_ack
);

  localparam int FILL_WIDTH = $clog2(`DIRCC_IN_FIFO_DEPTH + 1);

  int unsigned           assert_failures = 0; // failed assertions so far
  logic [FILL_WIDTH-1:0] in_fill; // input fifo fill seen from its handshakes

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      in_fill <= '0;
    end else begin
      in_fill <= in_fill + FILL_WIDTH'(in_valid && in_ready) -
                 FILL_WIDTH'(beat_valid && beat_ready);
    end
  end

  out_held: assert property (@(posedge clk) disable iff (!reset_n)
    out_valid && !out_ready |=> out_valid && $stable(out_packet))
    else begin
      $error("out_packet changed or out_valid fell before out_ready");
      assert_failures++;
    end

  ack_after_req: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(cfg_ack) |-> $past(cfg_req))
    else begin
      $error("cfg_ack rose without cfg_req");
      assert_failures++;
    end

  // first cycle after reset release still shows the reset value
  ready_unless_full: assert property (@(posedge clk) disable iff (!reset_n)
    $past(reset_n) && (in_fill != FILL_WIDTH'(`DIRCC_IN_FIFO_DEPTH)) |-> in_ready)
    else begin
      $error("in_ready low while the input fifo has room");
      assert_failures++;
    end

endmodule : dircc_receive_properties

bind dircc_receive_top dircc_receive_properties i_properties (
  .clk        (clk),
  .reset_n    (reset_n),
  .in_valid   (in_valid),
  .in_ready   (in_ready),
  .beat_valid (rx_beat_valid),
  .beat_ready (rx_beat_ready),
  .out_packet (out_packet),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .cfg_req    (cfg_req),
  .cfg_ack    (cfg_ack)
);

// File: dircc_receive_tb.sv
`timescale 1ns/1ns
`include "dircc_consts.svh"

module dircc_receive_tb;

  localparam int NUM_PACKETS    = 60; // upper bound over all tests
  localparam int TIMEOUT_CYCLES = NUM_PACKETS * `DIRCC_BEATS_PER_PACKET * 40;
  localparam logic [31:0] OWN_ADDR = 32'h0000_1234;

  logic                        clk = 1'b0;
  logic                        reset_n;
  logic [31:0]                 in_data;
  logic [1:0]                  in_empty;
  logic                        in_sop, in_eop, in_valid, in_ready;
  dircc_types_pkg::packet_t    out_packet;
  logic                        out_valid, out_ready;
  logic                        cfg_req, cfg_write, cfg_ack;
  dircc_stream_pkg::reg_addr_t cfg_addr;
  logic [31:0]                 cfg_wdata, cfg_rdata;

  dircc_types_pkg::packet_t exp_q[$]; // packets the model expects on the output
  logic [31:0]              model_own = '0;
  logic                     model_enable = 1'b0;
  logic                     model_bcast = 1'b0;
  int model_delivered = 0;
  int model_dropped = 0;
  int model_framing = 0;
  int events_sent = 0;
  int events_seen = 0; // packet_done or framing_error pulses
  int errors = 0;
  int errors_mark = 0;
  int test_num = 0;
  bit toggle_ready = 1'b0;

  always #5 clk = ~clk;

  dircc_receive_top i_dircc_receive_top (.*);

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (toggle_ready) out_ready = 1'($urandom_range(0, 1));
  endtask

  task automatic reg_access(input dircc_stream_pkg::reg_addr_t addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    cfg_addr  = addr;
    cfg_write = write;
    cfg_wdata = wdata;
    cfg_req   = 1'b1;
    do next_cycle(); while (!cfg_ack);
    rdata   = cfg_rdata;
    cfg_req = 1'b0;
    do next_cycle(); while (cfg_ack);
  endtask

  task automatic configure(input logic [31:0] addr, input logic en, input logic bcast);
    logic [31:0] rdata;
    reg_access(dircc_stream_pkg::REG_OWN_ADDR, 1'b1, addr, rdata);
    reg_access(dircc_stream_pkg::REG_CONTROL, 1'b1, {30'd0, bcast, en}, rdata);
    model_own    = addr;
    model_enable = en;
    model_bcast  = bcast;
  endtask

  task automatic check_counters();
    logic [31:0] rdata;
    reg_access(dircc_stream_pkg::REG_DELIVERED, 1'b0, 32'd0, rdata);
    check_value("REG_DELIVERED", 256'(rdata), 256'(model_delivered));
    reg_access(dircc_stream_pkg::REG_ERRORS, 1'b0, 32'd0, rdata);
    check_value("REG_ERRORS", 256'(rdata), 256'({model_framing[15:0], model_dropped[15:0]}));
  endtask

  // filter rule with out fifo room taken from the model queue
  task automatic decide(input dircc_types_pkg::packet_t p);
    logic match;
    match = model_enable && ((p.dest_addr.hw_addr == model_own) ||
            (model_bcast && (p.dest_addr.hw_addr == `DIRCC_BROADCAST_HW_ADDR)));
    if (match && (exp_q.size() < `DIRCC_OUT_FIFO_DEPTH)) begin
      exp_q.push_back(p);
      model_delivered++;
    end else begin
      model_dropped++;
    end
  endtask

  task automatic send_beat(input logic [31:0] data, input logic sop, input logic eop);
    logic was_ready;
    in_data  = data;
    in_empty = 2'd0;
    in_sop   = sop;
    in_eop   = eop;
    in_valid = 1'b1;
    do begin
      was_ready = in_ready;
      next_cycle();
    end while (!was_ready);
    in_valid = 1'b0;
    repeat ($urandom_range(0, 2)) next_cycle(); // valid gap
  endtask

  // kind 0 good, 1 missing sop, 2 early eop, 3 missing eop
  task automatic send_packet(input dircc_types_pkg::packet_t p, input int kind);
    logic [31:0] beats [10];
    int          n;
    beats[0] = p.dest_addr.hw_addr;
    beats[1] = {p.dest_addr.sw_addr, p.dest_addr.port, p.dest_addr.flag, 8'($urandom)};
    beats[2] = p.src_addr.hw_addr;
    beats[3] = {p.src_addr.sw_addr, p.src_addr.port, p.src_addr.flag, 8'($urandom)};
    beats[4] = p.lamport;
    beats[5] = p.data[31:0];
    beats[6] = p.data[63:32];
    beats[7] = p.data[95:64];
    beats[8] = $urandom;
    beats[9] = $urandom;
    n = (kind == 2) ? 5 : (kind == 3) ? 10 : 8; // overlong frame ends the discard
    if (kind == 0) decide(p);
    else model_framing++;
    for (int i = 0; i < n; i++) begin
      send_beat(beats[i], (i == 0) && (kind != 1), i == n - 1);
    end
    events_sent++;
  endtask

  function automatic dircc_types_pkg::packet_t random_packet(input logic [31:0] dest);
    dircc_types_pkg::packet_t p;
    p = 240'({$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom});
    p.dest_addr.hw_addr = dest;
    return p;
  endfunction

  function automatic logic [31:0] pick_dest();
    case ($urandom_range(0, 2))
      0:       return OWN_ADDR;
      1:       return `DIRCC_BROADCAST_HW_ADDR;
      default: return $urandom;
    endcase
  endfunction

  task automatic wait_settled();
    while ((events_seen < events_sent) || (out_ready && (exp_q.size() != 0))) next_cycle();
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("test %0d %s: done, %0d errors", test_num, name, errors - errors_mark);
    errors_mark = errors;
  endtask

  always @(negedge clk) begin
    if (i_dircc_receive_top.status_if.packet_done ||
        i_dircc_receive_top.status_if.framing_error) events_seen++;
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected packet on the output at %0t ns", $time);
        errors++;
      end else begin
        check_value("out_packet", 256'(out_packet), 256'(exp_q.pop_front()));
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    void'($urandom(32'hb1ee));
    reset_n   = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    in_empty  = '0;
    in_sop    = 1'b0;
    in_eop    = 1'b0;
    out_ready = 1'b1;
    cfg_req   = 1'b0;
    cfg_write = 1'b0;
    cfg_addr  = dircc_stream_pkg::REG_OWN_ADDR;
    cfg_wdata = '0;
    repeat (5) @(posedge clk);
    #1 reset_n = 1'b1;

    reg_access(dircc_stream_pkg::REG_OWN_ADDR, 1'b0, 32'd0, rdata);
    check_value("REG_OWN_ADDR", 256'(rdata), 256'(0));
    check_counters();
    configure(OWN_ADDR, 1'b1, 1'b1);
    reg_access(dircc_stream_pkg::REG_OWN_ADDR, 1'b0, 32'd0, rdata);
    check_value("REG_OWN_ADDR", 256'(rdata), 256'(OWN_ADDR));
    reg_access(dircc_stream_pkg::REG_CONTROL, 1'b0, 32'd0, rdata);
    check_value("REG_CONTROL", 256'(rdata), 256'(3));
    report_test("register access");

    configure(OWN_ADDR, 1'b1, 1'b0);
    repeat (12) send_packet(random_packet(OWN_ADDR), 0);
    wait_settled();
    check_counters();
    report_test("own address stream");

    for (int mode = 0; mode < 3; mode++) begin
      configure(OWN_ADDR, mode != 2, mode == 1); // bcast off, bcast on, disabled
      repeat (5) send_packet(random_packet(pick_dest()), 0);
      wait_settled();
    end
    check_counters();
    report_test("address filter");

    configure(OWN_ADDR, 1'b1, 1'b0);
    reg_access(dircc_stream_pkg::REG_ERRORS, 1'b1, 32'd0, rdata);
    model_framing = 0;
    model_dropped = 0;
    for (int kind = 1; kind < 4; kind++) begin
      send_packet(random_packet(OWN_ADDR), kind);
      send_packet(random_packet(OWN_ADDR), 0);
    end
    wait_settled();
    check_counters();
    report_test("framing errors");

    out_ready = 1'b0;
    repeat (6) send_packet(random_packet(OWN_ADDR), 0);
    wait_settled();
    check_counters();
    out_ready = 1'b1;
    wait_settled();
    toggle_ready = 1'b1;
    repeat (10) send_packet(random_packet(OWN_ADDR), 0);
    toggle_ready = 1'b0;
    out_ready = 1'b1;
    wait_settled();
    check_counters();
    report_test("output back-pressure");

    $display("%0d tests, %0d errors, %0d assertion failures", test_num, errors,
             i_dircc_receive_top.i_properties.assert_failures);
    if ((errors == 0) && (i_dircc_receive_top.i_properties.assert_failures == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : dircc_receive_tb

// File: project.f
+incdir+.
dircc_types_pkg.sv
dircc_stream_pkg.sv
dircc_rx_status_if.sv
dircc_sync_fifo.sv
dircc_packet_receiver.sv
dircc_address_filter.sv
dircc_receive_regs.sv
dircc_receive_top.sv
dircc_receive_properties.sv
dircc_receive_tb.sv

// File: Makefile
TOOL     = verilator
TOP      = dircc_receive_tb
FILELIST = project.f
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
SIM_ARGS = +verilator+error+limit+1000
BUILD    = obj_dir
LOG      = sim.log

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: sim clean
